// File: run_sim.sh
#!/bin/sh
# build the alu testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary -sv --top-module alu_tb -f sources.f -Mdir obj_dir -o alu_sim \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/alu_sim > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sources.f
+incdir+test
verilog/alu_pkg.sv
verilog/alu_decode.sv
verilog/alu_adder.sv
verilog/cond_eval.sv
verilog/alu_logic_ext.sv
verilog/alu_flags.sv
verilog/alu_retire.sv
verilog/alu_top.sv
test/alu_tb.sv

// File: test/alu_tb_model.svh
`ifndef ALU_TB_MODEL_SVH
`define ALU_TB_MODEL_SVH

// condition truth from the usual flag meanings
function automatic logic model_cond(flags_t f, cond_e cc);
  logic t;
  case (cc)
    COND_Z:   t = f.z;
    COND_NZ:  t = !f.z;
    COND_S:   t = f.s;
    COND_NS:  t = !f.s;
    COND_UGT: t = !f.c && !f.z;
    COND_ULE: t = f.c || f.z;
    COND_UGE: t = !f.c;
    COND_ULT: t = f.c;
    COND_SGT: t = (f.s == f.o) && !f.z;
    COND_SLE: t = (f.s != f.o) || f.z;
    COND_SGE: t = (f.s == f.o);
    COND_SLT: t = (f.s != f.o);
    COND_O:   t = f.o;
    COND_NO:  t = !f.o;
    COND_P:   t = f.p;
    COND_NP:  t = !f.p;
    default:  t = 1'b0;
  endcase
  return t;
endfunction

function automatic logic [DATA_W-1:0] ext_value(logic [DATA_W-1:0] b, ext_src_e src,
                                                logic sign_ext);
  int n;
  logic [DATA_W-1:0] v;
  n = (src == EXT_8) ? 8 : (src == EXT_16) ? 16 : 32;
  for (int i = 0; i < DATA_W; i++) begin
    v[i] = (i < n) ? b[i] : (sign_ext & b[n-1]);
  end
  return v;
endfunction

function automatic logic [DATA_W-1:0] model_result(alu_req_t r);
  logic [DATA_W-1:0] v;
  op_code_e code;
  code = r.op.arith.code;
  case (code)
    OP_ADD:  v = r.a + r.b;
    OP_SUB:  v = r.a - r.b;
    OP_AND:  v = r.a & r.b;
    OP_OR:   v = r.a | r.b;
    OP_XOR:  v = r.a ^ r.b;
    OP_MOV:  v = r.b;
    OP_ZXT:  return ext_value(r.b, r.op.arith.ext_src, 1'b0);  // always full width
    OP_SXT:  return ext_value(r.b, r.op.arith.ext_src, 1'b1);
    OP_CMOV: v = model_cond(r.flags_in, r.op.cond.cc) ? r.b : r.a;
    OP_CSET: v = 64'(model_cond(r.flags_in, r.op.cond.cc));
    default: v = '0;
  endcase
  if (!r.op.arith.is64) v[DATA_W-1:HALF_W] = '0;
  return v;
endfunction

function automatic logic model_sets(alu_req_t r);
  return r.op.arith.set_flags &&
         (r.op.arith.code inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR});
endfunction

function automatic flags_t model_flags(alu_req_t r);
  flags_t f;
  int w;
  logic [DATA_W-1:0] res;
  logic [DATA_W-1:0] am;
  logic [DATA_W-1:0] bm;
  logic [DATA_W:0] wide;
  logic [4:0] nib;
  logic sa;
  logic sb;
  logic sr;
  f = '0;
  if (!model_sets(r)) return f;
  w = r.op.arith.is64 ? DATA_W : HALF_W;
  res = model_result(r);
  am = r.op.arith.is64 ? r.a : {32'b0, r.a[HALF_W-1:0]};
  bm = r.op.arith.is64 ? r.b : {32'b0, r.b[HALF_W-1:0]};
  sa = r.a[w-1];
  sb = r.b[w-1];
  sr = res[w-1];
  f.s = sr;
  f.z = (res == '0);
  f.p = ($countones(res[7:0]) % 2) == 0;
  if (r.op.arith.code == OP_ADD) begin
    wide = {1'b0, am} + {1'b0, bm};
    nib = {1'b0, r.a[3:0]} + {1'b0, r.b[3:0]};
    f.c = wide[w];
    f.a = nib[4];
    f.o = (sa == sb) && (sr != sa);
  end else if (r.op.arith.code == OP_SUB) begin
    f.c = am < bm;  // borrow
    f.a = r.a[3:0] < r.b[3:0];
    f.o = (sa != sb) && (sr != sa);
  end
  return f;
endfunction

task automatic check_result(string what, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
  check_count++;
  if (got !== exp) begin
    $display("** Error at %0t: %s result %h, expected %h", $time, what, got, exp);
    err_count++;
    test_errs++;
  end
endtask

task automatic check_flags(string what, flags_t got, flags_t exp);
  check_count++;
  if (got !== exp) begin
    $display("** Error at %0t: %s flags (c o a s z p) %b, expected %b", $time, what, got, exp);
    err_count++;
    test_errs++;
  end
endtask

task automatic check_valid(string what, logic got, logic exp);
  check_count++;
  if (got !== exp) begin
    $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    err_count++;
    test_errs++;
  end
endtask

`endif

// File: test/alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_pkg::*; ();

  localparam int RST_CYCLES = 16;
  localparam int ADD_OPS = 48;
  localparam int LOGIC_OPS = 48;
  localparam int EXT_OPS = 56;
  localparam int COND_OPS = 128;
  localparam int B2B_OPS = 8;
  localparam int EXC_CYCLES = 40;
  localparam int TEST_CYCLES = RST_CYCLES + 2 + 2 * (ADD_OPS + LOGIC_OPS + EXT_OPS + COND_OPS)
                             + B2B_OPS + 3 + EXC_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic     clk;
  logic     rst;
  alu_req_t req;
  except_t  exc;
  alu_rsp_t rsp;

  int err_count;
  int test_errs;
  int check_count;
  int tests_run;
  int cycle_count;

  `include "alu_tb_model.svh"

  alu_top DUT (
    .clk (clk),
    .rst (rst),
    .req (req),
    .exc (exc),
    .rsp (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_count);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [DATA_W-1:0] rand64();
    return {$urandom(), $urandom()};
  endfunction

  function automatic alu_req_t arith_req(op_code_e code, logic is64, logic set_flags,
                                         ext_src_e ext, logic [DATA_W-1:0] a,
                                         logic [DATA_W-1:0] b);
    alu_req_t r;
    r = '0;
    r.valid = 1'b1;
    r.op.arith.code = code;
    r.op.arith.is64 = is64;
    r.op.arith.set_flags = set_flags;
    r.op.arith.ext_src = ext;
    r.a = a;
    r.b = b;
    return r;
  endfunction

  function automatic alu_req_t cond_req(op_code_e code, logic is64, cond_e cc, flags_t fl,
                                        logic [DATA_W-1:0] a, logic [DATA_W-1:0] b);
    alu_req_t r;
    r = '0;
    r.valid = 1'b1;
    r.op.cond.code = code;
    r.op.cond.is64 = is64;
    r.op.cond.cc = cc;
    r.flags_in = fl;
    r.a = a;
    r.b = b;
    return r;
  endfunction

  task automatic check_op(alu_req_t r, string what);
    check_valid({what, " valid"}, rsp.valid, 1'b1);
    check_result(what, rsp.result, model_result(r));
    check_flags(what, rsp.flags, model_flags(r));
    check_valid({what, " sets_flags"}, rsp.sets_flags, model_sets(r));
  endtask

  // one op, result checked in the cycle after issue
  task automatic run_op(alu_req_t r, string what);
    @(posedge clk);
    req <= r;
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    check_op(r, what);
  endtask

  task automatic end_test(string name);
    $display("%-16s %s, %0d errors", name, (test_errs == 0) ? "ok" : "failed", test_errs);
    tests_run++;
    test_errs = 0;
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_valid("valid after reset", rsp.valid, 1'b0);
    check_valid("sets_flags after reset", rsp.sets_flags, 1'b0);
    check_result("after reset", rsp.result, '0);
    check_flags("after reset", rsp.flags, '0);
    end_test("reset");
  endtask

  task automatic test_add_sub();
    logic [DATA_W-1:0] ca [6];
    logic [DATA_W-1:0] cb [6];
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    ca = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff,
           64'h8000_0000_0000_0000, 64'hdead_beef_7fff_ffff, 64'h5};
    cb = '{64'h0, 64'h1, 64'h1, 64'h8000_0000_0000_0000, 64'h1, 64'hf};
    for (int p = 0; p < ADD_OPS / 4; p++) begin
      a = (p < 6) ? ca[p] : rand64();
      b = (p < 6) ? cb[p] : rand64();
      for (int w = 0; w < 2; w++) begin
        run_op(arith_req(OP_ADD, w[0], 1'b1, EXT_8, a, b), $sformatf("add pair %0d", p));
        run_op(arith_req(OP_SUB, w[0], 1'b1, EXT_8, a, b), $sformatf("sub pair %0d", p));
      end
    end
    end_test("add_sub");
  endtask

  task automatic test_logic();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    for (int p = 0; p < 4; p++) begin
      a = (p == 0) ? '0 : (p == 3) ? 64'hffff_ffff_ffff_ffff : rand64();
      b = (p == 0) ? '0 : (p == 3) ? 64'h8000_0000_8000_0000 : rand64();
      // op from k % 3 and width/set_flags from k / 3
      for (int k = 0; k < 12; k++) begin
        run_op(arith_req(op_code_e'(6'(OP_AND + k % 3)), 1'((k / 3) % 2), 1'(k / 6), EXT_8,
                         a, b), $sformatf("logic pair %0d case %0d", p, k));
      end
    end
    end_test("logic");
  endtask

  task automatic test_move_ext();
    logic [DATA_W-1:0] b;
    for (int p = 0; p < 4; p++) begin
      b = (p == 0) ? 64'h80 : (p == 1) ? 64'h8000 : (p == 2) ? 64'h8000_0000 : rand64();
      b[DATA_W-1:HALF_W] = (p == 3) ? b[DATA_W-1:HALF_W] : 32'h1234_5678;  // upper junk
      for (int w = 0; w < 2; w++) begin
        run_op(arith_req(OP_MOV, w[0], 1'b0, EXT_8, rand64(), b), "mov");
        for (int k = 0; k < 3; k++) begin
          run_op(arith_req(OP_ZXT, w[0], 1'b0, ext_src_e'(2'(k)), rand64(), b),
                 $sformatf("zxt src %0d", k));
          run_op(arith_req(OP_SXT, w[0], 1'b0, ext_src_e'(2'(k)), rand64(), b),
                 $sformatf("sxt src %0d", k));
        end
      end
    end
    end_test("move_ext");
  endtask

  task automatic test_cond();
    flags_t fl;
    for (int c = 0; c < 16; c++) begin
      for (int j = 0; j < 4; j++) begin
        fl = 6'($urandom());
        run_op(cond_req(OP_CMOV, j[0], cond_e'(4'(c)), fl, rand64(), rand64()),
               $sformatf("cmov cond %0d", c));
        run_op(cond_req(OP_CSET, j[1], cond_e'(4'(c)), fl, rand64(), rand64()),
               $sformatf("cset cond %0d", c));
      end
    end
    end_test("cmov_cset");
  endtask

  task automatic test_back_to_back();
    alu_req_t ops [B2B_OPS];
    for (int i = 0; i < B2B_OPS; i++) begin
      ops[i] = arith_req(op_code_e'(6'(i)), i[0], 1'b1, EXT_16, rand64(), rand64());
      ops[i].thread = i[1];
    end
    for (int i = 0; i <= B2B_OPS; i++) begin
      @(posedge clk);
      req <= (i < B2B_OPS) ? ops[i] : '0;
      if (i > 0) begin
        @(negedge clk);
        check_op(ops[i-1], $sformatf("back-to-back op %0d", i - 1));
      end
    end
    @(posedge clk);
    @(negedge clk);
    check_valid("valid after last op", rsp.valid, 1'b0);
    end_test("back_to_back");
  endtask

  // lag 0 puts the exception in the issue cycle, lag 1 one cycle earlier
  task automatic issue_with_exc(alu_req_t r, int lag, logic exc_thread, logic exp_valid,
                                string what);
    @(posedge clk);
    exc <= '{valid: 1'b1, thread: exc_thread};
    for (int i = 0; i < lag; i++) begin
      @(posedge clk);
      exc <= '0;
    end
    req <= r;
    @(posedge clk);
    req <= '0;
    exc <= '0;
    @(negedge clk);
    check_valid({what, " valid"}, rsp.valid, exp_valid);
    check_result(what, rsp.result, model_result(r));
  endtask

  task automatic test_suppress();
    alu_req_t r;
    logic t;
    for (int i = 0; i < 2; i++) begin
      t = i[0];
      r = arith_req(OP_ADD, 1'b1, 1'b1, EXT_8, rand64(), rand64());
      r.thread = t;
      issue_with_exc(r, 0, t, 1'b0, "same thread, issue cycle");
      issue_with_exc(r, 1, t, 1'b0, "same thread, cycle before");
      issue_with_exc(r, 0, ~t, 1'b1, "other thread, issue cycle");
      issue_with_exc(r, 1, ~t, 1'b1, "other thread, cycle before");
      issue_with_exc(r, 2, t, 1'b1, "same thread, two cycles before");
    end
    end_test("suppress");
  endtask

  initial begin
    err_count = 0;
    test_errs = 0;
    check_count = 0;
    tests_run = 0;
    req = '0;
    exc = '0;
    rst = 1'b1;
    void'($urandom(32'he9cc));
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_add_sub();
    test_logic();
    test_move_ext();
    test_cond();
    test_back_to_back();
    test_suppress();
    $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/alu_adder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_adder import alu_pkg::*; (
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  ctl_t              ctl,
  output logic [DATA_W-1:0] sum,
  output logic              carry64,
  output logic              carry32,
  output logic              carry4
);

  logic [DATA_W-1:0]        b_op;
  logic [4:0]               lo;
  logic [HALF_W-4:0]        mid;
  logic [DATA_W-HALF_W:0]   hi;

  assign b_op = ctl.is_sub ? ~b : b;  // sub is a + ~b + 1

  // split at the nibble and half-word so the flag carries come out directly
  assign lo  = {1'b0, a[3:0]} + {1'b0, b_op[3:0]} + 5'(ctl.is_sub);
  assign mid = {1'b0, a[HALF_W-1:4]} + {1'b0, b_op[HALF_W-1:4]} + (HALF_W-3)'(lo[4]);
  assign hi  = {1'b0, a[DATA_W-1:HALF_W]} + {1'b0, b_op[DATA_W-1:HALF_W]}
             + (DATA_W-HALF_W+1)'(mid[HALF_W-4]);

  assign sum     = {hi[DATA_W-HALF_W-1:0], mid[HALF_W-5:0], lo[3:0]};
  assign carry4  = lo[4];
  assign carry32 = mid[HALF_W-4];
  assign carry64 = hi[DATA_W-HALF_W];

endmodule

`default_nettype wire

// File: verilog/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decode import alu_pkg::*; (
  input  op_word_u op,
  output ctl_t     ctl
);

  always_comb begin
    ctl = '0;
    // opcode sits in the low bits of both views
    case (op.arith.code)
      OP_ADD: ctl.is_add = 1'b1;
      OP_SUB: ctl.is_sub = 1'b1;
      OP_AND: begin
        ctl.is_logic   = 1'b1;
        ctl.logic_kind = LOGIC_AND;
      end
      OP_OR: begin
        ctl.is_logic   = 1'b1;
        ctl.logic_kind = LOGIC_OR;
      end
      OP_XOR: begin
        ctl.is_logic   = 1'b1;
        ctl.logic_kind = LOGIC_XOR;
      end
      OP_MOV:  ctl.is_mov  = 1'b1;
      OP_ZXT:  ctl.is_zxt  = 1'b1;
      OP_SXT:  ctl.is_sxt  = 1'b1;
      OP_CMOV: ctl.is_cmov = 1'b1;
      OP_CSET: ctl.is_cset = 1'b1;
      default: ;  // unknown op gives an all-zero result
    endcase

    ctl.is64 = op.arith.is64;  // same bit in both views
    if (!(ctl.is_cmov || ctl.is_cset)) begin
      ctl.ext_src = op.arith.ext_src;  // cond view holds cc here
    end

    // moves and conditionals never write flags
    ctl.sets_flags = (ctl.is_add | ctl.is_sub | ctl.is_logic) & op.arith.set_flags;
  end

endmodule

`default_nettype wire

// File: verilog/alu_flags.sv
`timescale 1ns/1ps
`default_nettype none

module alu_flags import alu_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  ctl_t              ctl,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] result,
  input  logic              carry64,
  input  logic              carry32,
  input  logic              carry4,
  output flags_t            flags,
  output logic [DATA_W-1:0] result_q,
  output logic              sets_flags
);

  logic is_add_q;
  logic is_sub_q;
  logic is64_q;
  logic c64_q;
  logic c32_q;
  logic c4_q;
  logic a_sign64_q;
  logic a_sign32_q;
  logic b_sign64_q;
  logic b_sign32_q;

  logic sign_r;
  logic sign_a;
  logic sign_b;
  logic zero_r;
  logic carry_w;
  logic add_ovf;
  logic sub_ovf;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_q   <= '0;
      is_add_q   <= 1'b0;
      is_sub_q   <= 1'b0;
      is64_q     <= 1'b0;
      sets_flags <= 1'b0;
    end else begin
      result_q   <= result;
      is_add_q   <= ctl.is_add;
      is_sub_q   <= ctl.is_sub;
      is64_q     <= ctl.is64;
      sets_flags <= ctl.sets_flags;
    end
  end

  always_ff @(posedge clk) begin
    c64_q      <= carry64;
    c32_q      <= carry32;
    c4_q       <= carry4;
    a_sign64_q <= a[DATA_W-1];
    a_sign32_q <= a[HALF_W-1];
    b_sign64_q <= b[DATA_W-1];
    b_sign32_q <= b[HALF_W-1];
  end

  assign sign_r  = is64_q ? result_q[DATA_W-1] : result_q[HALF_W-1];
  assign sign_a  = is64_q ? a_sign64_q : a_sign32_q;
  assign sign_b  = is64_q ? b_sign64_q : b_sign32_q;
  assign zero_r  = is64_q ? (result_q == '0) : (result_q[HALF_W-1:0] == '0);
  assign carry_w = is64_q ? c64_q : c32_q;

  assign add_ovf = (sign_a & sign_b & ~sign_r) | (~sign_a & ~sign_b & sign_r);
  assign sub_ovf = (sign_a & ~sign_b & ~sign_r) | (~sign_a & sign_b & sign_r);

  always_comb begin
    flags = '0;
    if (sets_flags) begin
      flags.s = sign_r;
      flags.z = zero_r;
      flags.p = ~^result_q[7:0];  // even parity of low byte
      if (is_add_q) begin
        flags.c = carry_w;
        flags.o = add_ovf;
        flags.a = c4_q;
      end else if (is_sub_q) begin
        // borrow is the inverted carry
        flags.c = ~carry_w;
        flags.o = sub_ovf;
        flags.a = ~c4_q;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu_logic_ext.sv
`timescale 1ns/1ps
`default_nettype none

module alu_logic_ext import alu_pkg::*; (
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] sum,
  input  ctl_t              ctl,
  input  logic              cond_true,
  output logic [DATA_W-1:0] result
);

  logic [DATA_W-1:0] logic_res;
  logic [DATA_W-1:0] zx_res;
  logic [DATA_W-1:0] sx_res;
  logic [DATA_W-1:0] ext_res;
  logic [DATA_W-1:0] cmov_res;
  logic [DATA_W-1:0] cset_res;
  logic [DATA_W-1:0] sel;
  logic              is_ext;

  always_comb begin
    case (ctl.logic_kind)
      LOGIC_OR:  logic_res = a | b;
      LOGIC_XOR: logic_res = a ^ b;
      default:   logic_res = a & b;
    endcase
  end

  always_comb begin
    case (ctl.ext_src)
      EXT_8: begin
        zx_res = {{(DATA_W-8){1'b0}}, b[7:0]};
        sx_res = {{(DATA_W-8){b[7]}}, b[7:0]};
      end
      EXT_16: begin
        zx_res = {{(DATA_W-16){1'b0}}, b[15:0]};
        sx_res = {{(DATA_W-16){b[15]}}, b[15:0]};
      end
      default: begin  // 32 bit source
        zx_res = {{(DATA_W-HALF_W){1'b0}}, b[HALF_W-1:0]};
        sx_res = {{(DATA_W-HALF_W){b[HALF_W-1]}}, b[HALF_W-1:0]};
      end
    endcase
  end

  assign is_ext   = ctl.is_zxt | ctl.is_sxt;
  assign ext_res  = ctl.is_sxt ? sx_res : zx_res;
  assign cmov_res = cond_true ? b : a;  // b is the move source
  assign cset_res = {{(DATA_W-1){1'b0}}, cond_true};

  always_comb begin
    if (ctl.is_add || ctl.is_sub) begin
      sel = sum;
    end else if (ctl.is_logic) begin
      sel = logic_res;
    end else if (ctl.is_mov) begin
      sel = b;
    end else if (is_ext) begin
      sel = ext_res;
    end else if (ctl.is_cmov) begin
      sel = cmov_res;
    end else if (ctl.is_cset) begin
      sel = cset_res;
    end else begin
      sel = '0;
    end
  end

  // 32 bit forms clear the upper half, extensions always write all 64
  assign result = (ctl.is64 || is_ext) ? sel
                                       : {{(DATA_W-HALF_W){1'b0}}, sel[HALF_W-1:0]};

endmodule

`default_nettype wire

// File: verilog/alu_pkg.sv
`default_nettype none

package alu_pkg;

  localparam int DATA_W = 64;
  localparam int HALF_W = 32;

  // logic_kind encodings in ctl_t
  localparam logic [1:0] LOGIC_AND = 2'd0;
  localparam logic [1:0] LOGIC_OR  = 2'd1;
  localparam logic [1:0] LOGIC_XOR = 2'd2;

  typedef enum logic [5:0] {
    OP_ADD  = 6'd0,
    OP_SUB  = 6'd1,
    OP_AND  = 6'd2,
    OP_OR   = 6'd3,
    OP_XOR  = 6'd4,
    OP_MOV  = 6'd5,
    OP_ZXT  = 6'd6,
    OP_SXT  = 6'd7,
    OP_CMOV = 6'd8,
    OP_CSET = 6'd9
  } op_code_e;

  typedef enum logic [3:0] {
    COND_Z, COND_NZ, COND_S, COND_NS,
    COND_UGT, COND_ULE, COND_UGE, COND_ULT,
    COND_SGT, COND_SLE, COND_SGE, COND_SLT,
    COND_O, COND_NO, COND_P, COND_NP
  } cond_e;

  typedef enum logic [1:0] {
    EXT_8  = 2'd0,
    EXT_16 = 2'd1,
    EXT_32 = 2'd2
  } ext_src_e;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef struct packed {
    logic     set_flags;
    logic     is64;
    ext_src_e ext_src;
    logic [1:0] rsvd;
    op_code_e code;
  } op_arith_t;

  typedef struct packed {
    logic     set_flags;
    logic     is64;
    cond_e    cc;
    op_code_e code;
  } op_cond_t;

  // upper half read per opcode, cond view only for cmov/cset
  typedef union packed {
    op_arith_t arith;
    op_cond_t  cond;
  } op_word_u;

  typedef struct packed {
    logic              valid;
    logic              thread;
    op_word_u          op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    flags_t            flags_in;
  } alu_req_t;

  typedef struct packed {
    logic valid;
    logic thread;
  } except_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] result;
    flags_t            flags;
    logic              sets_flags;
  } alu_rsp_t;

  typedef struct packed {
    logic       is_add;
    logic       is_sub;
    logic       is_logic;
    logic [1:0] logic_kind;
    logic       is_mov;
    logic       is_zxt;
    logic       is_sxt;
    logic       is_cmov;
    logic       is_cset;
    logic       is64;
    ext_src_e   ext_src;
    logic       sets_flags;
  } ctl_t;

endpackage

`default_nettype wire

// File: verilog/alu_retire.sv
`timescale 1ns/1ps
`default_nettype none

module alu_retire import alu_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    valid,
  input  logic    thread,
  input  except_t exc,
  output logic    rsp_valid
);

  except_t exc_q;  // exception seen one cycle back
  logic    kill;

  assign kill = (exc.valid && (exc.thread == thread)) ||
                (exc_q.valid && (exc_q.thread == thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      exc_q     <= '0;
      rsp_valid <= 1'b0;
    end else begin
      exc_q     <= exc;
      rsp_valid <= valid & ~kill;
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  alu_req_t req,
  input  except_t  exc,
  output alu_rsp_t rsp
);

  ctl_t              ctl;
  logic [DATA_W-1:0] sum;
  logic              carry64;
  logic              carry32;
  logic              carry4;
  logic              cond_true;
  logic [DATA_W-1:0] result;
  logic [DATA_W-1:0] result_q;
  flags_t            flags;
  logic              sets_flags;
  logic              rsp_valid;

  alu_decode u_decode (
    .op  (req.op),
    .ctl (ctl)
  );

  alu_adder u_adder (
    .a       (req.a),
    .b       (req.b),
    .ctl     (ctl),
    .sum     (sum),
    .carry64 (carry64),
    .carry32 (carry32),
    .carry4  (carry4)
  );

  cond_eval u_cond (
    .flags     (req.flags_in),
    .cond      (req.op.cond.cc),
    .cond_true (cond_true)
  );

  alu_logic_ext u_logic_ext (
    .a         (req.a),
    .b         (req.b),
    .sum       (sum),
    .ctl       (ctl),
    .cond_true (cond_true),
    .result    (result)
  );

  alu_flags u_flags (
    .clk        (clk),
    .rst        (rst),
    .ctl        (ctl),
    .a          (req.a),
    .b          (req.b),
    .result     (result),
    .carry64    (carry64),
    .carry32    (carry32),
    .carry4     (carry4),
    .flags      (flags),
    .result_q   (result_q),
    .sets_flags (sets_flags)
  );

  alu_retire u_retire (
    .clk       (clk),
    .rst       (rst),
    .valid     (req.valid),
    .thread    (req.thread),
    .exc       (exc),
    .rsp_valid (rsp_valid)
  );

  assign rsp = '{valid: rsp_valid, result: result_q, flags: flags, sets_flags: sets_flags};

endmodule

`default_nettype wire

// File: verilog/cond_eval.sv
`timescale 1ns/1ps
`default_nettype none

module cond_eval import alu_pkg::*; (
  input  flags_t flags,
  input  cond_e  cond,
  output logic   cond_true
);

  always_comb begin
    case (cond)
      COND_Z:   cond_true = flags.z;
      COND_NZ:  cond_true = ~flags.z;
      COND_S:   cond_true = flags.s;
      COND_NS:  cond_true = ~flags.s;
      COND_UGT: cond_true = ~(flags.c | flags.z);
      COND_ULE: cond_true = flags.c | flags.z;
      COND_UGE: cond_true = ~flags.c;
      COND_ULT: cond_true = flags.c;
      COND_SGT: cond_true = ~((flags.s ^ flags.o) | flags.z);
      COND_SLE: cond_true = (flags.s ^ flags.o) | flags.z;
      COND_SGE: cond_true = ~(flags.s ^ flags.o);
      COND_SLT: cond_true = flags.s ^ flags.o;
      COND_O:   cond_true = flags.o;
      COND_NO:  cond_true = ~flags.o;
      COND_P:   cond_true = flags.p;
      COND_NP:  cond_true = ~flags.p;
      default:  cond_true = 1'b0;
    endcase
  end

endmodule

`default_nettype wire
